/* hw/vga_text_pkg.sv */
package vga_text_pkg;

	// 640x480 at 60 Hz, horizontal timing in pixel clocks
	localparam int h_active = 640;
	localparam int h_front  = 16;
	localparam int h_sync   = 96;
	localparam int h_back   = 48;
	localparam int h_total  = h_active + h_front + h_sync + h_back;

	// vertical timing in lines
	localparam int v_active = 480;
	localparam int v_front  = 10;
	localparam int v_sync   = 2;
	localparam int v_back   = 33;
	localparam int v_total  = v_active + v_front + v_sync + v_back;

	// 8x8 character grid
	localparam int text_cols  = 80;
	localparam int text_rows  = 60;
	localparam int text_cells = text_cols * text_rows;

	// coordinate in to pixel out, in clocks
	localparam int render_latency = 2;

	typedef logic [9:0]  hcount_t;
	typedef logic [9:0]  vcount_t;
	typedef logic [12:0] cell_addr_t;
	typedef logic [7:0]  cell_t;
	typedef logic [23:0] rgb_t;
	typedef logic [63:0] glyph_t;
	typedef logic [12:0] wb_addr_t;

	// foreground colours, picked by the upper nibble of a cell
	localparam rgb_t fg_palette [16] = '{
		24'hffffff,
		24'hff0000,
		24'h00ff00,
		24'h0000ff,
		24'hffff00,
		24'h00ffff,
		24'hff00ff,
		24'hc0c0c0,
		24'h808080,
		24'h800000,
		24'h008000,
		24'h000080,
		24'h808000,
		24'h008080,
		24'h800080,
		24'hffa500
	};

endpackage

/* hw/vga_timing.sv */
`timescale 1ns/1ns

module vga_timing
	import vga_text_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	output hcount_t h_addr,
	output vcount_t v_addr,
	output logic    active,
	output logic    hsync_raw,
	output logic    vsync_raw
);

	hcount_t h_next;
	vcount_t v_next;
	logic    h_wrap;
	logic    h_in_sync;
	logic    v_in_sync;
	logic    next_active;

	// next position, decoded one clock early so outputs stay aligned
	always_comb begin
		h_wrap = (h_addr == hcount_t'(h_total - 1));
		if (h_wrap) begin
			h_next = '0;
		end else begin
			h_next = h_addr + hcount_t'(1);
		end
	end

	always_comb begin
		v_next = v_addr;
		if (h_wrap) begin
			if (v_addr == vcount_t'(v_total - 1)) begin
				v_next = '0;
			end else begin
				v_next = v_addr + vcount_t'(1);
			end
		end
	end

	// sync pulses sit between front and back porch
	assign h_in_sync = (h_next >= hcount_t'(h_active + h_front)) &&
		(h_next < hcount_t'(h_active + h_front + h_sync));
	assign v_in_sync = (v_next >= vcount_t'(v_active + v_front)) &&
		(v_next < vcount_t'(v_active + v_front + v_sync));
	assign next_active = (h_next < hcount_t'(h_active)) &&
		(v_next < vcount_t'(v_active));

	always_ff @(posedge clk) begin
		if (rst) begin
			h_addr    <= '0;
			v_addr    <= '0;
			// pixel (0,0) is visible
			active    <= 1'b1;
			hsync_raw <= 1'b1;
			vsync_raw <= 1'b1;
		end else begin
			h_addr    <= h_next;
			v_addr    <= v_next;
			active    <= next_active;
			hsync_raw <= ~h_in_sync;
			vsync_raw <= ~v_in_sync;
		end
	end

endmodule

/* hw/text_buffer.sv */
`timescale 1ns/1ns

module text_buffer
	import vga_text_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  wb_addr_t   wb_adr,
	input  cell_t      wb_dat_w,
	output logic       wb_ack,
	output cell_t      wb_dat_r,
	input  cell_addr_t vid_addr,
	output cell_t      vid_cell
);

	typedef enum logic [1:0] {
		st_clear,
		st_idle,
		st_ack
	} buf_state_t;

	buf_state_t state;
	cell_addr_t clr_addr;
	logic       clr_last;
	logic       wb_start;
	logic       wb_in_range;

	cell_t mem [text_cells];

	assign clr_last    = (clr_addr == cell_addr_t'(text_cells - 1));
	assign wb_in_range = (wb_adr < wb_addr_t'(text_cells));
	// new request, only taken once the clear sweep is done
	assign wb_start    = (state == st_idle) && wb_cyc && wb_stb;
	assign wb_ack      = (state == st_ack);

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= st_clear;
			clr_addr <= '0;
		end else begin
			case (state)
				st_clear: begin
					if (clr_last) begin
						state <= st_idle;
					end else begin
						clr_addr <= clr_addr + cell_addr_t'(1);
					end
				end
				st_idle: begin
					if (wb_start) begin
						state <= st_ack;
					end
				end
				// host drops stb after seeing ack
				st_ack: begin
					state <= st_idle;
				end
				default: begin
					state <= st_clear;
				end
			endcase
		end
	end

	// single write port, shared by clear sweep and host
	always_ff @(posedge clk) begin
		if (state == st_clear) begin
			mem[clr_addr] <= '0;
		end else if (wb_start && wb_we && wb_in_range) begin
			mem[wb_adr] <= wb_dat_w;
		end
	end

	// host read, held for the ack cycle
	always_ff @(posedge clk) begin
		if (wb_start) begin
			if (!wb_we && wb_in_range) begin
				wb_dat_r <= mem[wb_adr];
			end else begin
				wb_dat_r <= '0;
			end
		end
	end

	// video read, every clock
	always_ff @(posedge clk) begin
		vid_cell <= mem[vid_addr];
	end

endmodule

/* hw/glyph_render.sv */
`timescale 1ns/1ns

module glyph_render
	import vga_text_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  hcount_t    h_addr,
	input  vcount_t    v_addr,
	input  logic       active,
	input  logic       hsync_raw,
	input  logic       vsync_raw,
	input  cell_t      vid_cell,
	output cell_addr_t vid_addr,
	output logic       vga_hsync,
	output logic       vga_vsync,
	output logic       vga_blank_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);

	cell_addr_t row_base;
	cell_addr_t cell_addr;

	logic [2:0] glyph_row_q;
	logic [2:0] glyph_col_q;

	logic [render_latency-1:0] active_d;
	logic [render_latency-1:0] hsync_d;
	logic [render_latency-1:0] vsync_d;

	glyph_t     font_rom [16];
	glyph_t     glyph;
	logic [5:0] bit_idx;
	logic       pixel_on;
	rgb_t       fg_color;
	rgb_t       pixel_rgb;

	// one bitmap per hex digit, top-left pixel in bit 63
	initial begin
		$readmemh("hw/font_hex8x8.hex", font_rom);
	end

	// stage 1: cell index is row * 80 + column
	assign row_base  = cell_addr_t'(v_addr[9:3]) * cell_addr_t'(text_cols);
	assign cell_addr = row_base + cell_addr_t'(h_addr[9:3]);

	// outside the visible area the counters run past the grid
	assign vid_addr = active ? cell_addr : '0;

	always_ff @(posedge clk) begin
		glyph_row_q <= v_addr[2:0];
		glyph_col_q <= h_addr[2:0];
	end

	// stage 2: glyph bit lookup, cell byte arrives from the buffer
	always_comb begin
		glyph    = font_rom[vid_cell[3:0]];
		bit_idx  = {glyph_row_q, glyph_col_q};
		pixel_on = glyph[6'd63 - bit_idx];
		fg_color = fg_palette[vid_cell[7:4]];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pixel_rgb <= '0;
		end else if (active_d[0] && pixel_on) begin
			pixel_rgb <= fg_color;
		end else begin
			// background is black
			pixel_rgb <= '0;
		end
	end

	// control delay matching the colour path
	always_ff @(posedge clk) begin
		if (rst) begin
			active_d <= '0;
			hsync_d  <= '1;
			vsync_d  <= '1;
		end else begin
			active_d <= {active_d[render_latency-2:0], active};
			hsync_d  <= {hsync_d[render_latency-2:0], hsync_raw};
			vsync_d  <= {vsync_d[render_latency-2:0], vsync_raw};
		end
	end

	assign vga_blank_n = active_d[render_latency-1];
	assign vga_hsync   = hsync_d[render_latency-1];
	assign vga_vsync   = vsync_d[render_latency-1];
	assign vga_r       = pixel_rgb[23:16];
	assign vga_g       = pixel_rgb[15:8];
	assign vga_b       = pixel_rgb[7:0];

endmodule

/* hw/vga_text_top.sv */
`timescale 1ns/1ns

module vga_text_top
	import vga_text_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  wb_addr_t   wb_adr,
	input  cell_t      wb_dat_w,
	output logic       wb_ack,
	output cell_t      wb_dat_r,
	output logic       vga_hsync,
	output logic       vga_vsync,
	output logic       vga_blank_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);

	hcount_t    h_addr;
	vcount_t    v_addr;
	logic       active;
	logic       hsync_raw;
	logic       vsync_raw;
	cell_addr_t vid_addr;
	cell_t      vid_cell;

	vga_timing timing (
		.clk(clk),
		.rst(rst),
		.h_addr(h_addr),
		.v_addr(v_addr),
		.active(active),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw)
	);

	// host side and video side share the character RAM
	text_buffer buffer (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r),
		.vid_addr(vid_addr),
		.vid_cell(vid_cell)
	);

	glyph_render render (
		.clk(clk),
		.rst(rst),
		.h_addr(h_addr),
		.v_addr(v_addr),
		.active(active),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw),
		.vid_cell(vid_cell),
		.vid_addr(vid_addr),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.vga_blank_n(vga_blank_n),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

/* verification/vga_text_chk.sv */
`timescale 1ns/1ns

module vga_text_chk
	import vga_text_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input logic       wb_cyc,
	input logic       wb_stb,
	input logic       wb_ack,
	input logic       vga_hsync,
	input logic       vga_blank_n,
	input logic [7:0] vga_r,
	input logic [7:0] vga_g,
	input logic [7:0] vga_b
);

	int hs_low_cnt;

	// length of the current hsync low run
	always_ff @(posedge clk) begin
		if (rst) begin
			hs_low_cnt <= 0;
		end else if (!vga_hsync) begin
			hs_low_cnt <= hs_low_cnt + 1;
		end else begin
			hs_low_cnt <= 0;
		end
	end

	ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_ack |=> !wb_ack)
		else $error("wb_ack stayed high for two cycles");

	ack_after_request: assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack without a preceding strobe");

	blank_is_black: assert property (@(posedge clk) disable iff (rst)
		!vga_blank_n |-> ({vga_r, vga_g, vga_b} == 24'h0))
		else $error("colour output not black while blanked");

	hsync_width: assert property (@(posedge clk) disable iff (rst)
		$rose(vga_hsync) |-> (hs_low_cnt == h_sync))
		else $error("hsync low for %0d cycles", hs_low_cnt);

endmodule

/* verification/vga_text_tb.sv */
`timescale 1ns/1ns

module vga_text_tb
	import vga_text_pkg::*;
();

	localparam int clk_period    = 100;
	localparam int frame_cycles  = h_total * v_total;
	localparam int timeout_limit = 3 * frame_cycles + 10000;
	localparam int n_table       = 9;
	localparam int n_random      = 6;
	localparam int blank_addr    = 50 * text_cols + 20;
	localparam int max_prints    = 20;

	typedef enum int {scan_off, scan_wait, scan_active, scan_done} scan_state_t;

	logic       clk;
	logic       rst;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	wb_addr_t   wb_adr;
	cell_t      wb_dat_w;
	logic       wb_ack;
	cell_t      wb_dat_r;
	logic       vga_hsync;
	logic       vga_vsync;
	logic       vga_blank_n;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	// column, row and cell byte; row 60 column 0 is address 4800, past the grid
	int    tab_col  [n_table] = '{0, 79, 0, 79, 40, 10, 33, 65, 0};
	int    tab_row  [n_table] = '{0, 0, 59, 59, 30, 20, 7, 44, 60};
	cell_t tab_cell [n_table] = '{8'h1a, 8'h2f, 8'h30, 8'h48, 8'hf5, 8'h07,
		8'h9c, 8'he3, 8'h5a};

	cell_t       model_mem  [text_cells];
	logic        check_cell [text_cells];
	glyph_t      font_copy  [16];
	cell_addr_t  rand_addr  [n_random];
	cell_t       rand_cell  [n_random];
	logic [31:0] lfsr_state;

	int err_reset;
	int err_bus;
	int err_sync;
	int err_pixel;
	int err_blank;
	int cycle_count = 0;
	int pixels_checked;
	int flood_prints;

	logic        hs_prev;
	logic        vs_prev;
	logic        hs_fall_seen;
	logic        vs_fall_seen;
	logic        frame_locked;
	int          hs_low_len;
	int          vs_low_len;
	int          hs_since_fall;
	int          vs_since_fall;
	int          hs_periods;
	int          vs_periods;
	int          col_cnt;
	int          line_cnt;
	scan_state_t scan_state;

	vga_text_top UUT (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.vga_blank_n(vga_blank_n),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

	bind vga_text_top vga_text_chk chk (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_ack(wb_ack),
		.vga_hsync(vga_hsync),
		.vga_blank_n(vga_blank_n),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("timeout: run did not complete within %0d cycles", timeout_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	// bit 63 of a glyph is its top-left pixel
	function automatic rgb_t expected_pixel(input int x, input int y);
		cell_t  cell_byte;
		glyph_t glyph;
		int     idx;
		cell_byte = model_mem[(y / 8) * text_cols + x / 8];
		glyph     = font_copy[cell_byte[3:0]];
		idx       = (y % 8) * 8 + x % 8;
		if (glyph[63 - idx]) begin
			return fg_palette[cell_byte[7:4]];
		end
		return '0;
	endfunction

	task automatic compare_reset(input string name, input logic [23:0] got,
		input logic [23:0] want);
		if (got !== want) begin
			err_reset++;
			$display("MISMATCH %s in reset: got %h expected %h", name, got, want);
		end
	endtask

	task automatic apply_reset();
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			if (i == 4) begin
				rst <= 1'b0;
			end
			@(negedge clk);
			compare_reset("vga_hsync", 24'(vga_hsync), 24'h1);
			compare_reset("vga_vsync", 24'(vga_vsync), 24'h1);
			compare_reset("vga_blank_n", 24'(vga_blank_n), 24'h0);
			compare_reset("vga_rgb", {vga_r, vga_g, vga_b}, 24'h0);
			compare_reset("wb_ack", 24'(wb_ack), 24'h0);
		end
	endtask

	task automatic wb_cycle(input logic we, input wb_addr_t adr, input cell_t wdat,
		input int max_wait, output cell_t rdat, output int lat);
		int waited;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdat;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (wb_ack !== 1'b1 && waited < max_wait);
		rdat = wb_dat_r;
		lat  = waited;
		if (wb_ack !== 1'b1) begin
			err_bus++;
			lat = -1;
			$display("wishbone access to address %h got no acknowledge", adr);
		end
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	// strobe is visible at the first sample, ack one clock later at the second
	task automatic check_latency(input wb_addr_t adr, input bit strict, input int lat);
		if (strict && lat > 0 && lat != 2) begin
			err_bus++;
			$display("MISMATCH wb_ack latency at %h: got %h expected %h", adr, lat, 2);
		end
	endtask

	task automatic write_cell(input wb_addr_t adr, input cell_t data, input bit strict);
		cell_t rdat;
		int    lat;
		wb_cycle(1'b1, adr, data, strict ? 4 : text_cells + 16, rdat, lat);
		check_latency(adr, strict, lat);
		if (adr < text_cells) begin
			model_mem[adr]  = data;
			check_cell[adr] = 1'b1;
		end
	endtask

	task automatic read_check(input wb_addr_t adr, input bit strict);
		cell_t rdat;
		cell_t want;
		int    lat;
		wb_cycle(1'b0, adr, 8'h00, strict ? 4 : text_cells + 16, rdat, lat);
		check_latency(adr, strict, lat);
		want = (adr < text_cells) ? model_mem[adr] : 8'h00;
		if (lat > 0 && rdat !== want) begin
			err_bus++;
			$display("MISMATCH wb_dat_r at %h: got %h expected %h", adr, rdat, want);
		end
	endtask

	// pixel position from the sync edges, visible area starts h_back after hsync rise
	task automatic check_position();
		int   x;
		int   y;
		logic in_view;
		rgb_t got;
		rgb_t want;
		x       = col_cnt - h_back;
		y       = line_cnt + 1 - v_back;
		in_view = (x >= 0 && x < h_active && y >= 0 && y < v_active);
		got     = {vga_r, vga_g, vga_b};
		if (vga_blank_n !== in_view) begin
			err_blank++;
			if (flood_prints < max_prints) begin
				flood_prints++;
				$display("MISMATCH vga_blank_n at x %0d y %0d: got %h expected %h",
					x, y, vga_blank_n, in_view);
			end
		end
		if (scan_state == scan_active && in_view) begin
			if (check_cell[(y / 8) * text_cols + x / 8]) begin
				want = expected_pixel(x, y);
				pixels_checked++;
				if (got !== want) begin
					err_pixel++;
					if (flood_prints < max_prints) begin
						flood_prints++;
						$display("MISMATCH vga_rgb at x %0d y %0d: got %h expected %h",
							x, y, got, want);
					end
				end
			end
			if (x == h_active - 1 && y == v_active - 1) begin
				scan_state = scan_done;
			end
		end
	endtask

	// outputs are sampled half a clock after the DUT updates them
	always @(negedge clk) begin
		if (!rst) begin
			if (vga_blank_n !== 1'b1 && {vga_r, vga_g, vga_b} !== 24'h0) begin
				err_blank++;
				if (flood_prints < max_prints) begin
					flood_prints++;
					$display("MISMATCH vga_rgb while blanked: got %h expected %h",
						{vga_r, vga_g, vga_b}, 24'h0);
				end
			end
			hs_since_fall++;
			vs_since_fall++;
			if (!vga_hsync) begin
				hs_low_len++;
			end
			if (!vga_vsync) begin
				vs_low_len++;
			end
			if (hs_prev && !vga_hsync) begin
				if (hs_fall_seen && hs_since_fall != h_total) begin
					err_sync++;
					$display("MISMATCH vga_hsync period: got %h expected %h",
						hs_since_fall, h_total);
				end
				if (hs_fall_seen) begin
					hs_periods++;
				end
				hs_fall_seen  = 1'b1;
				hs_since_fall = 0;
				hs_low_len    = 1;
			end
			if (vs_prev && !vga_vsync) begin
				if (vs_fall_seen && vs_since_fall != frame_cycles) begin
					err_sync++;
					$display("MISMATCH vga_vsync period: got %h expected %h",
						vs_since_fall, frame_cycles);
				end
				if (vs_fall_seen) begin
					vs_periods++;
				end
				vs_fall_seen  = 1'b1;
				vs_since_fall = 0;
				vs_low_len    = 1;
			end
			if (!hs_prev && vga_hsync && hs_fall_seen && hs_low_len != h_sync) begin
				err_sync++;
				$display("MISMATCH vga_hsync low width: got %h expected %h",
					hs_low_len, h_sync);
			end
			if (!vs_prev && vga_vsync && vs_fall_seen && vs_low_len != v_sync * h_total) begin
				err_sync++;
				$display("MISMATCH vga_vsync low width: got %h expected %h",
					vs_low_len, v_sync * h_total);
			end
			// line 0 follows v_back lines after the vsync rise
			if (!vs_prev && vga_vsync) begin
				frame_locked = 1'b1;
				line_cnt     = -1;
				if (scan_state == scan_wait) begin
					scan_state = scan_active;
				end
			end
			if (!hs_prev && vga_hsync) begin
				line_cnt++;
				col_cnt = 0;
			end else begin
				col_cnt++;
			end
			if (frame_locked) begin
				check_position();
			end
			hs_prev = vga_hsync;
			vs_prev = vga_vsync;
		end
	end

	initial begin
		logic [31:0] val;
		int          n_marked;
		int          total;
		clk      = 1'b0;
		rst      = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		lfsr_state = 32'hd82e6fd7;
		err_reset = 0;
		err_bus   = 0;
		err_sync  = 0;
		err_pixel = 0;
		err_blank = 0;
		pixels_checked = 0;
		flood_prints   = 0;
		hs_prev = 1'b1;
		vs_prev = 1'b1;
		hs_fall_seen = 1'b0;
		vs_fall_seen = 1'b0;
		frame_locked = 1'b0;
		hs_low_len = 0;
		vs_low_len = 0;
		hs_since_fall = 0;
		vs_since_fall = 0;
		hs_periods = 0;
		vs_periods = 0;
		col_cnt  = 0;
		line_cnt = 0;
		scan_state = scan_off;
		$readmemh("hw/font_hex8x8.hex", font_copy);
		for (int i = 0; i < text_cells; i++) begin
			model_mem[i]  = 8'h00;
			check_cell[i] = 1'b0;
		end

		apply_reset();

		// unwritten cell, also waits out the clear sweep after reset
		check_cell[blank_addr] = 1'b1;
		read_check(wb_addr_t'(blank_addr), 1'b0);

		for (int i = 0; i < n_table; i++) begin
			write_cell(wb_addr_t'(tab_row[i] * text_cols + tab_col[i]), tab_cell[i], 1'b1);
		end
		for (int i = 0; i < n_random; i++) begin
			take_bits(13, val);
			rand_addr[i] = cell_addr_t'(val % text_cells);
			if (rand_addr[i] == cell_addr_t'(blank_addr)) begin
				rand_addr[i] = rand_addr[i] + 1'b1;
			end
			take_bits(8, val);
			rand_cell[i] = val[7:0];
			write_cell(wb_addr_t'(rand_addr[i]), rand_cell[i], 1'b1);
		end

		for (int i = 0; i < n_table; i++) begin
			read_check(wb_addr_t'(tab_row[i] * text_cols + tab_col[i]), 1'b1);
		end
		for (int i = 0; i < n_random; i++) begin
			read_check(wb_addr_t'(rand_addr[i]), 1'b1);
		end
		read_check(wb_addr_t'(blank_addr), 1'b1);

		// pixels are checked over the next full frame
		scan_state = scan_wait;
		while (scan_state != scan_done) begin
			@(posedge clk);
		end
		while (vs_periods < 1 || hs_periods < 1) begin
			@(posedge clk);
		end

		n_marked = 0;
		for (int i = 0; i < text_cells; i++) begin
			if (check_cell[i]) begin
				n_marked++;
			end
		end
		if (pixels_checked != 64 * n_marked) begin
			err_pixel++;
			$display("render check covered %0d pixels instead of %0d",
				pixels_checked, 64 * n_marked);
		end

		total = err_reset + err_bus + err_sync + err_pixel + err_blank;
		$display("errors: reset %0d, bus %0d, sync %0d, pixel %0d, blanking %0d, total %0d",
			err_reset, err_bus, err_sync, err_pixel, err_blank, total);
		if (total == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* hw/font_hex8x8.hex */
// one 8x8 glyph per line, hex digits 0 to F in order
// first byte is the top row, msb of each byte is the leftmost pixel
3C666E7666663C00
1838181818187E00
3C66060C30607E00
3C66061C06663C00
0C1C3C6C7E0C0C00
7E607C0606663C00
3C607C6666663C00
7E060C1830303000
3C66663C66663C00
3C66663E060C3800
183C66667E666600
7C66667C66667C00
3C66606060663C00
786C6666666C7800
7E60607C60607E00
7E60607C60606000

/* vlog.f */
hw/vga_text_pkg.sv
hw/vga_timing.sv
hw/text_buffer.sv
hw/glyph_render.sv
hw/vga_text_top.sv
verification/vga_text_chk.sv
verification/vga_text_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the VGA text testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module vga_text_tb \
	-f vlog.f \
	-o vga_text_sim

./obj_dir/vga_text_sim 2>&1 | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
	echo "simulation result: passed"
	exit 0
else
	echo "simulation result: failed"
	exit 1
fi
